//--- src/isaPkg.sv
package isaPkg;

    localparam int opWidth = 3;
    localparam int progDepth = 8;   // pc wraps at this depth

    // opcode encoding taken straight from the switches
    typedef enum logic [opWidth-1:0]
    {
        opLoad    = 3'd0,   // memory top onto operand stack
        opStore   = 3'd1,   // operand top into memory stack
        opSub     = 3'd2,
        opAdd     = 3'd3,
        opMul     = 3'd4,
        opDiv     = 3'd5,
        opDisplay = 3'd6,
        opNop     = 3'd7
    } opcodeT;

    // value sits on the upper four switches
    typedef struct packed
    {
        logic [3:0] value;
        opcodeT     opcode;
    } switchWord;

endpackage

//--- src/dataPkg.sv
package dataPkg;

    localparam int dataWidth = 4;
    localparam int operandDepth = 8;
    localparam int memDepth = 16;

    typedef logic [dataWidth-1:0] dataT;

    // at most one of push/pop/popTwo set
    typedef struct packed
    {
        logic push;
        logic pop;
        logic popTwo;
        logic fromMemory;   // push memory top instead of switch value
    } operandCmd;

    typedef struct packed
    {
        logic push;
        logic pop;
    } memCmd;

    typedef enum logic [2:0]
    {
        aluSub,
        aluAdd,
        aluMul,
        aluDiv,
        aluShow
    } aluOpT;

    // outA is the leftmost of four hex digits
    typedef struct packed
    {
        dataT outA;
        dataT outB;
        dataT hi;
        dataT lo;
    } resultWord;

endpackage

//--- src/programMemory.sv
`timescale 1ns/1ps

module programMemory
(
    input  logic            clk,
    input  logic            reset,
    input  logic            progShift,
    input  isaPkg::opcodeT  newOp,
    input  logic [2:0]      pc,
    output isaPkg::opcodeT  progWord
);

    isaPkg::opcodeT prog [isaPkg::progDepth];

    assign progWord = prog[pc];

    // newest opcode always at address 0
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < isaPkg::progDepth; i++)
                prog[i] <= isaPkg::opLoad;
        end
        else if (progShift)
        begin
            prog[0] <= newOp;
            for (int i = 1; i < isaPkg::progDepth; i++)
                prog[i] <= prog[i-1];   // oldest falls off the end
        end
    end

endmodule

//--- src/operandStack.sv
`timescale 1ns/1ps

module operandStack
(
    input  logic                clk,
    input  logic                reset,
    input  dataPkg::operandCmd  opCmd,
    input  dataPkg::dataT       swValue,
    input  dataPkg::dataT       memTop,
    output dataPkg::dataT       stackTop,
    output dataPkg::dataT       stackNext
);

    localparam int depth = dataPkg::operandDepth;

    dataPkg::dataT entry [depth];   // entry 0 is the top
    dataPkg::dataT pushWord;

    assign pushWord  = opCmd.fromMemory ? memTop : swValue;
    assign stackTop  = entry[0];
    assign stackNext = entry[1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < depth; i++)
                entry[i] <= '0;
        end
        else if (opCmd.push)
        begin
            // full stack loses its bottom entry
            entry[0] <= pushWord;
            for (int i = 1; i < depth; i++)
                entry[i] <= entry[i-1];
        end
        else if (opCmd.popTwo)
        begin
            for (int i = 0; i < depth - 2; i++)
                entry[i] <= entry[i+2];
            entry[depth-2] <= '0;
            entry[depth-1] <= '0;
        end
        else if (opCmd.pop)
        begin
            for (int i = 0; i < depth - 1; i++)
                entry[i] <= entry[i+1];
            entry[depth-1] <= '0;   // zero fill from bottom
        end
    end

endmodule

//--- src/memoryStack.sv
`timescale 1ns/1ps

module memoryStack
(
    input  logic            clk,
    input  logic            reset,
    input  dataPkg::memCmd  mCmd,
    input  dataPkg::dataT   pushValue,
    output dataPkg::dataT   memTop
);

    localparam int depth = dataPkg::memDepth;

    dataPkg::dataT mem [depth];

    assign memTop = mem[0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < depth; i++)
                mem[i] <= '0;
        end
        else if (mCmd.push)
        begin
            mem[0] <= pushValue;
            for (int i = 1; i < depth; i++)
                mem[i] <= mem[i-1];
        end
        else if (mCmd.pop)
        begin
            for (int i = 0; i < depth - 1; i++)
                mem[i] <= mem[i+1];
            mem[depth-1] <= '0;
        end
    end

endmodule

//--- src/arithUnit.sv
`timescale 1ns/1ps

module arithUnit
(
    input  logic                clk,
    input  logic                reset,
    input  logic                aluStrobe,
    input  dataPkg::aluOpT      aluOp,
    input  dataPkg::dataT       a,
    input  dataPkg::dataT       b,
    output dataPkg::resultWord  result
);

    dataPkg::resultWord nextResult;

    always_comb
    begin
        nextResult      = '0;
        nextResult.outA = a;
        nextResult.outB = b;
        case (aluOp)
            dataPkg::aluSub:
                nextResult.lo = a - b;   // mod 16
            dataPkg::aluAdd:
                nextResult.lo = a + b;
            dataPkg::aluMul:
                nextResult.lo = a * b;   // low nibble only
            dataPkg::aluDiv:
            begin
                if (b == '0)
                begin
                    // divide by zero saturates the quotient
                    nextResult.hi = '1;
                    nextResult.lo = a;
                end
                else
                begin
                    nextResult.hi = a / b;
                    nextResult.lo = a % b;
                end
            end
            dataPkg::aluShow:
                nextResult.outB = a;     // single value on both digits
            default:
                nextResult.outB = b;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            result <= '0;
        else if (aluStrobe)
            result <= nextResult;
    end

endmodule

//--- src/cpuController.sv
`timescale 1ns/1ps

module cpuController
(
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::switchWord   sw,
    input  logic                loadOperand,
    input  logic                loadProgram,
    input  logic                runStep,
    input  logic                runExternal,
    input  isaPkg::opcodeT      progWord,
    output logic                ready,
    output logic                resultValid,
    output logic                progShift,
    output logic                aluStrobe,
    output logic [2:0]          pc,
    output dataPkg::operandCmd  opCmd,
    output dataPkg::memCmd      mCmd,
    output dataPkg::aluOpT      aluOp
);

    typedef enum logic [2:0]
    {
        stIdle,
        stLoadOperand,
        stLoadProgram,
        stFetch,
        stExecute,
        stReport
    } stateT;

    stateT          state;
    isaPkg::opcodeT instr;

    assign ready = (state == stIdle);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= stIdle;
            pc          <= 3'd0;
            instr       <= isaPkg::opLoad;
            resultValid <= 1'b0;
        end
        else
        begin
            resultValid <= aluStrobe;   // one cycle after the result loads
            case (state)
                stIdle:
                begin
                    if (loadOperand)
                        state <= stLoadOperand;
                    else if (loadProgram)
                        state <= stLoadProgram;
                    else if (runStep)
                        state <= stFetch;
                    else if (runExternal)
                    begin
                        instr <= sw.opcode;   // pc untouched
                        state <= stExecute;
                    end
                end
                stFetch:
                begin
                    instr <= progWord;
                    pc    <= pc + 3'd1;     // wraps 7 -> 0
                    state <= stExecute;
                end
                stLoadOperand,
                stLoadProgram,
                stExecute:
                    state <= stReport;
                default:
                    state <= stIdle;
            endcase
        end
    end

    // stack and memory commands
    always_comb
    begin
        opCmd     = '0;
        mCmd      = '0;
        progShift = 1'b0;
        aluStrobe = 1'b0;
        case (state)
            stLoadOperand:
                opCmd.push = 1'b1;
            stLoadProgram:
                progShift = 1'b1;
            stExecute:
            begin
                case (instr)
                    isaPkg::opLoad:
                    begin
                        mCmd.pop         = 1'b1;
                        opCmd.push       = 1'b1;
                        opCmd.fromMemory = 1'b1;
                    end
                    isaPkg::opStore:
                    begin
                        opCmd.pop = 1'b1;
                        mCmd.push = 1'b1;
                    end
                    isaPkg::opSub,
                    isaPkg::opAdd,
                    isaPkg::opMul,
                    isaPkg::opDiv:
                    begin
                        opCmd.popTwo = 1'b1;
                        aluStrobe    = 1'b1;
                    end
                    isaPkg::opDisplay:
                    begin
                        opCmd.pop = 1'b1;
                        aluStrobe = 1'b1;
                    end
                    default:
                        aluStrobe = 1'b0;   // nop
                endcase
            end
            default:
                progShift = 1'b0;
        endcase
    end

    always_comb
    begin
        case (instr)
            isaPkg::opSub: aluOp = dataPkg::aluSub;
            isaPkg::opAdd: aluOp = dataPkg::aluAdd;
            isaPkg::opMul: aluOp = dataPkg::aluMul;
            isaPkg::opDiv: aluOp = dataPkg::aluDiv;
            default:       aluOp = dataPkg::aluShow;
        endcase
    end

endmodule

//--- src/stackCpu.sv
`timescale 1ns/1ps

module stackCpu
(
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::switchWord   sw,
    input  logic                loadOperand,
    input  logic                loadProgram,
    input  logic                runStep,
    input  logic                runExternal,
    output logic                ready,
    output logic                resultValid,
    output dataPkg::resultWord  result
);

    isaPkg::opcodeT     progWord;
    logic               progShift;
    logic               aluStrobe;
    logic [2:0]         pc;
    dataPkg::operandCmd opCmd;
    dataPkg::memCmd     mCmd;
    dataPkg::aluOpT     aluOp;
    dataPkg::dataT      stackTop;
    dataPkg::dataT      stackNext;
    dataPkg::dataT      memTop;

    cpuController i_cpuController
    (
        .clk         (clk),
        .reset       (reset),
        .sw          (sw),
        .loadOperand (loadOperand),
        .loadProgram (loadProgram),
        .runStep     (runStep),
        .runExternal (runExternal),
        .progWord    (progWord),
        .ready       (ready),
        .resultValid (resultValid),
        .progShift   (progShift),
        .aluStrobe   (aluStrobe),
        .pc          (pc),
        .opCmd       (opCmd),
        .mCmd        (mCmd),
        .aluOp       (aluOp)
    );

    programMemory i_programMemory
    (
        .clk       (clk),
        .reset     (reset),
        .progShift (progShift),
        .newOp     (sw.opcode),
        .pc        (pc),
        .progWord  (progWord)
    );

    operandStack i_operandStack
    (
        .clk       (clk),
        .reset     (reset),
        .opCmd     (opCmd),
        .swValue   (sw.value),
        .memTop    (memTop),
        .stackTop  (stackTop),
        .stackNext (stackNext)
    );

    // store pushes the operand top
    memoryStack i_memoryStack
    (
        .clk       (clk),
        .reset     (reset),
        .mCmd      (mCmd),
        .pushValue (stackTop),
        .memTop    (memTop)
    );

    arithUnit i_arithUnit
    (
        .clk       (clk),
        .reset     (reset),
        .aluStrobe (aluStrobe),
        .aluOp     (aluOp),
        .a         (stackTop),
        .b         (stackNext),
        .result    (result)
    );

endmodule

//--- test/tbModel.svh
`ifndef tbModelSvh
`define tbModelSvh

// index 0 is the top of each stack
dataPkg::dataT  opModel[$];
dataPkg::dataT  memModel[$];
isaPkg::opcodeT progModel [isaPkg::progDepth] = '{default: isaPkg::opLoad};
int             pcModel = 0;

function automatic void pushOperand(dataPkg::dataT v);
    opModel.push_front(v);
    if (opModel.size() > dataPkg::operandDepth)
        void'(opModel.pop_back());   // bottom entry lost
endfunction

function automatic dataPkg::dataT popOperand();
    if (opModel.size() == 0)
        return '0;   // empty reads zero
    return opModel.pop_front();
endfunction

function automatic void pushMemory(dataPkg::dataT v);
    memModel.push_front(v);
    if (memModel.size() > dataPkg::memDepth)
        void'(memModel.pop_back());
endfunction

function automatic dataPkg::dataT popMemory();
    if (memModel.size() == 0)
        return '0;
    return memModel.pop_front();
endfunction

// newest opcode lands at address 0
function automatic void shiftProgram(isaPkg::opcodeT op);
    for (int i = isaPkg::progDepth - 1; i > 0; i--)
        progModel[i] = progModel[i-1];
    progModel[0] = op;
endfunction

function automatic dataPkg::resultWord expectResult(isaPkg::opcodeT op,
                                                    dataPkg::dataT a, dataPkg::dataT b);
    dataPkg::resultWord r;
    int x;
    int y;
    x = a;
    y = b;
    r = '0;
    r.outA = a;
    r.outB = b;
    case (op)
        isaPkg::opSub: r.lo = dataPkg::dataT'((x - y + 16) % 16);
        isaPkg::opAdd: r.lo = dataPkg::dataT'((x + y) % 16);
        isaPkg::opMul: r.lo = dataPkg::dataT'((x * y) % 16);
        isaPkg::opDiv:
        begin
            r.hi = (y == 0) ? 4'd15 : dataPkg::dataT'(x / y);
            r.lo = (y == 0) ? a : dataPkg::dataT'(x % y);
        end
        isaPkg::opDisplay: r.outB = a;   // one value on both sides
        default: r = '0;
    endcase
    return r;
endfunction

// applies one opcode and returns 1 when a result gets reported
function automatic bit modelExecute(input isaPkg::opcodeT op, output dataPkg::resultWord res);
    dataPkg::dataT a;
    res = '0;
    case (op)
        isaPkg::opLoad: pushOperand(popMemory());
        isaPkg::opStore: pushMemory(popOperand());
        isaPkg::opNop: return 1'b0;
        isaPkg::opDisplay: res = expectResult(op, popOperand(), '0);
        default:
        begin
            a = popOperand();
            res = expectResult(op, a, popOperand());
        end
    endcase
    return (op != isaPkg::opLoad) && (op != isaPkg::opStore);
endfunction

`endif

//--- test/tbStackCpu.sv
`timescale 1ns/1ps

module tbStackCpu;

    typedef enum {pulseOperand, pulseProgram, pulseStep, pulseExternal} pulseT;

    localparam int readyTimeout = 20;

    logic               clk = 1'b0;
    logic               reset;
    isaPkg::switchWord  sw;
    logic               loadOperand;
    logic               loadProgram;
    logic               runStep;
    logic               runExternal;
    logic               ready;
    logic               resultValid;
    dataPkg::resultWord result;

    dataPkg::resultWord expectQ[$];
    int                 errorCount = 0;
    int                 checkCount = 0;
    bit                 timedOut = 1'b0;

    `include "tbModel.svh"

    stackCpu i_stackCpu (.*);

    always #10 clk = ~clk;

    task automatic compareResult(dataPkg::resultWord got, dataPkg::resultWord exp);
        checkCount++;
        if (got !== exp)
        begin
            $display("[ERROR] %0t result got %h expected %h", $time, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        checkCount++;
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic finishRun();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    // later pulses are skipped once ready has been lost
    task automatic waitReady();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ready && cycles < readyTimeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!ready)
        begin
            $display("ready did not come back within %0d cycles", readyTimeout);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic sendPulse(pulseT kind, dataPkg::dataT value, isaPkg::opcodeT op);
        if (timedOut)
            return;
        waitReady();
        if (timedOut)
            return;
        @(posedge clk);
        sw.value  <= value;
        sw.opcode <= op;
        case (kind)
            pulseOperand: loadOperand <= 1'b1;
            pulseProgram: loadProgram <= 1'b1;
            pulseStep:    runStep <= 1'b1;
            default:      runExternal <= 1'b1;
        endcase
        @(posedge clk);
        loadOperand <= 1'b0;
        loadProgram <= 1'b0;
        runStep     <= 1'b0;
        runExternal <= 1'b0;
        @(negedge clk);
        compareBit("ready", ready, 1'b0);   // low once the pulse is taken
        waitReady();
    endtask

    task automatic pushValue(dataPkg::dataT v);
        pushOperand(v);
        sendPulse(pulseOperand, v, isaPkg::opNop);
    endtask

    task automatic writeOpcode(isaPkg::opcodeT op);
        shiftProgram(op);
        sendPulse(pulseProgram, 4'd0, op);
    endtask

    task automatic runOpcode(isaPkg::opcodeT op);
        dataPkg::resultWord r;
        if (modelExecute(op, r))
            expectQ.push_back(r);
        sendPulse(pulseExternal, 4'd0, op);
    endtask

    task automatic stepProgram();
        dataPkg::resultWord r;
        isaPkg::opcodeT op;
        op = progModel[pcModel];
        pcModel = (pcModel + 1) % isaPkg::progDepth;
        if (modelExecute(op, r))
            expectQ.push_back(r);
        sendPulse(pulseStep, 4'd0, isaPkg::opNop);
    endtask

    // every resultValid cycle consumes one expected result
    always @(negedge clk)
    begin
        if (!reset && resultValid)
        begin
            if (expectQ.size() == 0)
            begin
                $display("resultValid was raised with no result pending");
                errorCount++;
            end
            else
                compareResult(result, expectQ.pop_front());
        end
    end

    initial
    begin
        void'($urandom(32'h3c5ea4aa));
        reset       <= 1'b1;
        sw          <= '0;
        loadOperand <= 1'b0;
        loadProgram <= 1'b0;
        runStep     <= 1'b0;
        runExternal <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compareBit("ready", ready, 1'b1);
        compareBit("resultValid", resultValid, 1'b0);
        runOpcode(isaPkg::opDisplay);   // empty stack

        for (int i = 0; i < 8; i++)
            pushValue(dataPkg::dataT'($urandom));
        for (int i = 0; i < 6; i++)
            runOpcode(isaPkg::opcodeT'(isaPkg::opSub + $urandom_range(3)));

        // b of zero under a random a
        pushValue(4'd0);
        pushValue(dataPkg::dataT'($urandom));
        runOpcode(isaPkg::opDiv);

        for (int i = 0; i < 4; i++)
            pushValue(dataPkg::dataT'($urandom));
        repeat (4) runOpcode(isaPkg::opStore);
        repeat (4)
        begin
            runOpcode(isaPkg::opLoad);
            runOpcode(isaPkg::opDisplay);
        end

        // steps wrap past address 7
        for (int i = 0; i < 8; i++)
            pushValue(dataPkg::dataT'($urandom));
        for (int i = 0; i < 8; i++)
            writeOpcode(isaPkg::opcodeT'($urandom_range(7)));
        repeat (12) stepProgram();

        for (int i = 0; i < 10; i++)
            pushValue(dataPkg::dataT'($urandom));
        repeat (9) runOpcode(isaPkg::opDisplay);   // last one shows zeros

        if (!timedOut && expectQ.size() != 0)
        begin
            $display("%0d expected results were never reported", expectQ.size());
            errorCount++;
        end
        finishRun();
    end

endmodule

//--- files.f
+incdir+test
src/isaPkg.sv
src/dataPkg.sv
src/programMemory.sv
src/operandStack.sv
src/memoryStack.sv
src/arithUnit.sv
src/cpuController.sv
src/stackCpu.sv
test/tbStackCpu.sv
